//--- src.f
hw/ex_pkg.sv
hw/ex_op_if.sv
hw/ex_alu.sv
hw/ex_divider.sv
hw/ex_branch.sv
hw/ex_ctrl.sv
hw/ex_top.sv
dv/ex_tb.sv

//--- run.sh
#!/bin/sh
# build the execute stage testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module ex_tb -f src.f -o ex_sim &&
  ./obj_dir/ex_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TESTBENCH PASSED" sim.log && echo "simulation passed" && exit 0 ||
  { echo "simulation failed"; exit 1; }

//--- dv/ex_tb.sv
// ex_tb: directed testbench for the RV64IM execute stage with an operator-level model
`timescale 1ns/1ns
`default_nettype none

module ex_tb;

  // about 150 issues at up to 70 cycles each plus margin
  localparam int TIMEOUT_CYCLES = 20000;
  localparam ex_pkg::xlen_t SMIN = 64'h8000_0000_0000_0000;
  localparam ex_pkg::xlen_t SMAX = 64'h7fff_ffff_ffff_ffff;
  localparam ex_pkg::xlen_t ONES = 64'hffff_ffff_ffff_ffff;

  logic            i_clk, i_rst, i_valid, o_ready, i_a_pc, i_word_cut;
  logic            o_res_valid, i_res_ready;
  ex_pkg::xlen_t   i_rs1, i_rs2, i_imm, i_pc, o_result, o_next_pc;
  ex_pkg::alu_op_t i_alu_op;
  ex_pkg::bsrc_t   i_b_src;
  ex_pkg::branch_t i_branch;
  logic [31:0]     lfsr;
  int              n_checks, n_errors, cycle_count;

  ex_top UUT (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_valid     (i_valid),
    .o_ready     (o_ready),
    .i_rs1       (i_rs1),
    .i_rs2       (i_rs2),
    .i_imm       (i_imm),
    .i_pc        (i_pc),
    .i_alu_op    (i_alu_op),
    .i_a_pc      (i_a_pc),
    .i_word_cut  (i_word_cut),
    .i_b_src     (i_b_src),
    .i_branch    (i_branch),
    .o_res_valid (o_res_valid),
    .i_res_ready (i_res_ready),
    .o_result    (o_result),
    .o_next_pc   (o_next_pc)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge i_clk);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

  // fibonacci lfsr with taps 32 22 2 1
  // stepped once for each bit taken
  function automatic ex_pkg::xlen_t rand_bits(input int n);
    ex_pkg::xlen_t v;
    int            k;
    v = '0;
    for (k = 0; k < n; k++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic ex_pkg::xlen_t operand_a(input ex_pkg::xlen_t rs1, pc,
                                              input logic a_pc, word);
    if (a_pc)
      return pc;
    return word ? {32'b0, rs1[31:0]} : rs1;
  endfunction

  function automatic ex_pkg::xlen_t operand_b(input ex_pkg::xlen_t rs2, imm,
                                              input ex_pkg::bsrc_t bsrc, input logic word);
    if (bsrc == ex_pkg::BSRC_FOUR)
      return 64'd4;
    if (bsrc == ex_pkg::BSRC_IMM)
      return word ? {32'b0, imm[31:0]} : imm;
    return word ? {32'b0, rs2[31:0]} : rs2;
  endfunction

  // RISC-V division rules with word forms on the low 32 bits
  function automatic ex_pkg::xlen_t div_model(input ex_pkg::alu_op_t op,
                                              input ex_pkg::xlen_t a, b, input logic word);
    logic          sgn;
    ex_pkg::xlen_t x, y, q, rm;
    sgn = (op == ex_pkg::ALU_DIV) || (op == ex_pkg::ALU_REM);
    x = a;
    y = b;
    if (word) begin
      x = sgn ? {{32{a[31]}}, a[31:0]} : {32'b0, a[31:0]};
      y = sgn ? {{32{b[31]}}, b[31:0]} : {32'b0, b[31:0]};
    end
    if (y == '0) begin
      q  = ONES;
      rm = x;
    end else if (sgn && x == SMIN && y == ONES) begin
      q  = x;
      rm = '0;
    end else if (sgn) begin
      q  = $signed(x) / $signed(y);
      rm = $signed(x) % $signed(y);
    end else begin
      q  = x / y;
      rm = x % y;
    end
    return (op == ex_pkg::ALU_REM || op == ex_pkg::ALU_REMU) ? rm : q;
  endfunction

  function automatic ex_pkg::xlen_t result_model(input ex_pkg::alu_op_t op,
                                                 input ex_pkg::xlen_t a, b, imm,
                                                 input logic word);
    logic [127:0]  pa, pb, prod;
    logic [31:0]   w32;
    logic [5:0]    sh;
    ex_pkg::xlen_t r;
    sh = word ? {1'b0, b[4:0]} : b[5:0];
    pa = {{64{a[63]}}, a};
    pb = {{64{b[63]}}, b};
    if (op == ex_pkg::ALU_MULHSU || op == ex_pkg::ALU_MULHU)
      pb[127:64] = '0;
    if (op == ex_pkg::ALU_MULHU)
      pa[127:64] = '0;
    prod = pa * pb;
    w32 = $signed(a[31:0]) >>> sh;
    case (op)
      ex_pkg::ALU_ADD:    r = a + b;
      ex_pkg::ALU_SUB:    r = a - b;
      ex_pkg::ALU_SLT:    r = {63'b0, $signed(a) < $signed(b)};
      ex_pkg::ALU_SLTU:   r = {63'b0, a < b};
      ex_pkg::ALU_XOR:    r = a ^ b;
      ex_pkg::ALU_AND:    r = a & b;
      ex_pkg::ALU_OR:     r = a | b;
      ex_pkg::ALU_SLL:    r = a << sh;
      ex_pkg::ALU_SRL:    r = a >> sh;
      ex_pkg::ALU_SRA:    r = $signed(a) >>> sh;
      ex_pkg::ALU_MUL:    r = prod[63:0];
      ex_pkg::ALU_MULH,
      ex_pkg::ALU_MULHSU,
      ex_pkg::ALU_MULHU:  r = prod[127:64];
      ex_pkg::ALU_COPY:   r = imm;
      default:            r = div_model(op, a, b, word);
    endcase
    if (op == ex_pkg::ALU_SRA && word)
      r = {32'b0, w32};
    return word ? {{32{r[31]}}, r[31:0]} : r;
  endfunction

  function automatic ex_pkg::xlen_t next_pc_model(input ex_pkg::alu_op_t op,
                                                  input ex_pkg::branch_t br,
                                                  input ex_pkg::xlen_t rs1, pc, imm, a, b);
    logic less, taken;
    less = (op == ex_pkg::ALU_SLTU) ? (a < b) : ($signed(a) < $signed(b));
    case (br)
      ex_pkg::BR_JAL,
      ex_pkg::BR_JALR: taken = 1'b1;
      ex_pkg::BR_EQ:   taken = (a == b);
      ex_pkg::BR_NE:   taken = (a != b);
      ex_pkg::BR_LT:   taken = less;
      ex_pkg::BR_GE:   taken = !less;
      default:         taken = 1'b0;
    endcase
    return ((br == ex_pkg::BR_JALR) ? rs1 : pc) + (taken ? imm : 64'd4);
  endfunction

  // issue one instruction and check it, then hold the result before taking it
  task automatic run_op(input string name, input ex_pkg::alu_op_t op,
                        input ex_pkg::xlen_t rs1, rs2, imm, pc, input logic a_pc, word,
                        input ex_pkg::bsrc_t bsrc, input ex_pkg::branch_t br, input int hold);
    ex_pkg::xlen_t a, b, exp_res, exp_pc, held_res, held_pc;
    int            exp_lat, lat;
    a = operand_a(rs1, pc, a_pc, word);
    b = operand_b(rs2, imm, bsrc, word);
    exp_res = result_model(op, a, b, imm, word);
    exp_pc  = next_pc_model(op, br, rs1, pc, imm, a, b);
    exp_lat = 1;
    if (op inside {ex_pkg::ALU_DIV, ex_pkg::ALU_DIVU, ex_pkg::ALU_REM, ex_pkg::ALU_REMU})
      exp_lat = word ? 34 : 66;
    @(negedge i_clk);
    while (!o_ready)
      @(negedge i_clk);
    @(posedge i_clk);
    i_valid    <= 1'b1;
    i_rs1      <= rs1;
    i_rs2      <= rs2;
    i_imm      <= imm;
    i_pc       <= pc;
    i_alu_op   <= op;
    i_a_pc     <= a_pc;
    i_word_cut <= word;
    i_b_src    <= bsrc;
    i_branch   <= br;
    // issue edge
    @(posedge i_clk);
    i_valid <= 1'b0;
    lat = 0;
    @(negedge i_clk);
    while (!o_res_valid) begin
      n_checks++;
      if (o_ready) begin
        n_errors++;
        $display("%s: o_ready went high before the result was taken", name);
      end
      @(negedge i_clk);
      lat++;
    end
    n_checks += 3;
    if (lat != exp_lat) begin
      n_errors++;
      $display("error %s latency: expected %0d actual %0d", name, exp_lat, lat);
    end
    if (o_result !== exp_res) begin
      n_errors++;
      $display("error %s result: expected %h actual %h", name, exp_res, o_result);
    end
    if (o_next_pc !== exp_pc) begin
      n_errors++;
      $display("error %s next pc: expected %h actual %h", name, exp_pc, o_next_pc);
    end
    held_res = o_result;
    held_pc  = o_next_pc;
    // a competing issue must be refused while the result is held
    repeat (hold) begin
      @(posedge i_clk);
      i_valid <= 1'b1;
      i_rs1   <= ~rs1;
      @(negedge i_clk);
      n_checks++;
      if (!o_res_valid || o_ready || o_result !== held_res || o_next_pc !== held_pc) begin
        n_errors++;
        $display("%s: held result changed or a new issue was accepted", name);
      end
    end
    @(posedge i_clk);
    i_res_ready <= 1'b1;
    // result taken here
    @(posedge i_clk);
    i_res_ready <= 1'b0;
    i_valid     <= 1'b0;
    @(negedge i_clk);
    n_checks++;
    if (o_res_valid || !o_ready) begin
      n_errors++;
      $display("%s: stage did not return to ready after the result was taken", name);
    end
  endtask

  task automatic basic_alu_ops;
    ex_pkg::alu_op_t ops [9];
    int              i, j;
    ops = '{ex_pkg::ALU_ADD, ex_pkg::ALU_SUB, ex_pkg::ALU_XOR, ex_pkg::ALU_AND, ex_pkg::ALU_OR,
            ex_pkg::ALU_COPY, ex_pkg::ALU_SLL, ex_pkg::ALU_SRL, ex_pkg::ALU_SRA};
    for (i = 0; i < 9; i++) begin
      for (j = 0; j < 3; j++) begin
        run_op($sformatf("alu op %0d bsrc %0d", ops[i], j), ops[i], rand_bits(64),
               rand_bits(64), rand_bits(64), rand_bits(64), j[0], 1'b0,
               ex_pkg::bsrc_t'(j), ex_pkg::BR_NONE, 0);
      end
    end
  endtask

  task automatic word_forms_and_compares;
    ex_pkg::alu_op_t wops [5];
    ex_pkg::xlen_t   ea [5];
    ex_pkg::xlen_t   eb [5];
    int              i, j;
    wops = '{ex_pkg::ALU_ADD, ex_pkg::ALU_SUB, ex_pkg::ALU_SLL, ex_pkg::ALU_SRL,
             ex_pkg::ALU_SRA};
    // equal operands and both sides of the sign boundary
    ea = '{64'h1234, SMAX, SMIN, ONES, 64'd0};
    eb = '{64'h1234, SMIN, SMAX, 64'd0, ONES};
    for (i = 0; i < 5; i++) begin
      for (j = 0; j < 2; j++) begin
        run_op($sformatf("word op %0d", wops[i]), wops[i], rand_bits(64), rand_bits(64),
               rand_bits(64), rand_bits(64), 1'b0, 1'b1,
               j[0] ? ex_pkg::BSRC_IMM : ex_pkg::BSRC_RS2, ex_pkg::BR_NONE, 0);
        run_op($sformatf("compare edge %0d", i), j[0] ? ex_pkg::ALU_SLTU : ex_pkg::ALU_SLT,
               ea[i], eb[i], rand_bits(64), rand_bits(64), 1'b0, 1'b0, ex_pkg::BSRC_RS2,
               ex_pkg::BR_NONE, 0);
      end
    end
    for (i = 0; i < 4; i++) begin
      run_op("compare random", i[0] ? ex_pkg::ALU_SLTU : ex_pkg::ALU_SLT, rand_bits(64),
             rand_bits(64), rand_bits(64), rand_bits(64), 1'b0, 1'b0, ex_pkg::BSRC_RS2,
             ex_pkg::BR_NONE, 0);
    end
  endtask

  task automatic multiplies;
    ex_pkg::alu_op_t mops [4];
    ex_pkg::xlen_t   ea [4];
    ex_pkg::xlen_t   eb [4];
    int              i, k;
    mops = '{ex_pkg::ALU_MUL, ex_pkg::ALU_MULH, ex_pkg::ALU_MULHSU, ex_pkg::ALU_MULHU};
    ea = '{SMIN, SMIN, ONES, SMAX};
    eb = '{SMIN, ONES, ONES, SMIN};
    for (i = 0; i < 4; i++) begin
      for (k = 0; k < 3; k++) begin
        run_op($sformatf("mul random op %0d", mops[i]), mops[i], rand_bits(64),
               rand_bits(64), rand_bits(64), rand_bits(64), 1'b0, 1'b0, ex_pkg::BSRC_RS2,
               ex_pkg::BR_NONE, 0);
      end
      for (k = 0; k < 4; k++) begin
        run_op($sformatf("mul extreme op %0d case %0d", mops[i], k), mops[i], ea[k], eb[k],
               rand_bits(64), rand_bits(64), 1'b0, 1'b0, ex_pkg::BSRC_RS2,
               ex_pkg::BR_NONE, 0);
      end
    end
  endtask

  task automatic divides;
    ex_pkg::alu_op_t dops [4];
    int              i, k, w;
    dops = '{ex_pkg::ALU_DIV, ex_pkg::ALU_DIVU, ex_pkg::ALU_REM, ex_pkg::ALU_REMU};
    for (i = 0; i < 4; i++) begin
      for (w = 0; w < 2; w++) begin
        for (k = 0; k < 3; k++) begin
          run_op($sformatf("div op %0d word %0d", dops[i], w), dops[i], rand_bits(64),
                 rand_bits(64) >> rand_bits(6), rand_bits(64), rand_bits(64), 1'b0, w[0],
                 ex_pkg::BSRC_RS2, ex_pkg::BR_NONE, 0);
        end
        run_op($sformatf("div by zero op %0d word %0d", dops[i], w), dops[i], rand_bits(64),
               64'd0, rand_bits(64), rand_bits(64), 1'b0, w[0], ex_pkg::BSRC_RS2,
               ex_pkg::BR_NONE, 0);
      end
    end
    for (i = 0; i < 2; i++) begin
      run_op("div overflow", i[0] ? ex_pkg::ALU_REM : ex_pkg::ALU_DIV, SMIN, ONES,
             rand_bits(64), rand_bits(64), 1'b0, 1'b0, ex_pkg::BSRC_RS2, ex_pkg::BR_NONE, 0);
      run_op("divw overflow", i[0] ? ex_pkg::ALU_REM : ex_pkg::ALU_DIV, 64'h8000_0000, ONES,
             rand_bits(64), rand_bits(64), 1'b0, 1'b1, ex_pkg::BSRC_RS2, ex_pkg::BR_NONE, 0);
    end
  endtask

  task automatic branch_targets;
    ex_pkg::branch_t cond [4];
    ex_pkg::branch_t jump [3];
    ex_pkg::xlen_t   ra, rb;
    int              i, k;
    cond = '{ex_pkg::BR_EQ, ex_pkg::BR_NE, ex_pkg::BR_LT, ex_pkg::BR_GE};
    jump = '{ex_pkg::BR_JAL, ex_pkg::BR_JALR, ex_pkg::BR_NONE};
    for (i = 0; i < 4; i++) begin
      for (k = 0; k < 4; k++) begin
        // case 0 has equal operands and cases 1 and 2 cross the sign boundary
        // case 3 repeats case 1 compared unsigned
        ra = rand_bits(64);
        rb = ra;
        if (k == 1 || k == 3) begin
          ra = ONES;
          rb = 64'd1;
        end else if (k == 2) begin
          ra = 64'd1;
          rb = ONES;
        end
        run_op($sformatf("branch %0d case %0d", cond[i], k),
               (k == 3) ? ex_pkg::ALU_SLTU : ex_pkg::ALU_SLT, ra, rb, rand_bits(64),
               rand_bits(64), 1'b0, 1'b0, ex_pkg::BSRC_RS2, cond[i], 0);
      end
    end
    // link value pc + 4 as a jump would write it
    for (i = 0; i < 3; i++) begin
      run_op($sformatf("jump %0d", jump[i]), ex_pkg::ALU_ADD, rand_bits(64), rand_bits(64),
             rand_bits(64), rand_bits(64), 1'b1, 1'b0, ex_pkg::BSRC_FOUR, jump[i], 0);
    end
  endtask

  task automatic result_backpressure;
    run_op("backpressure add", ex_pkg::ALU_ADD, rand_bits(64), rand_bits(64), rand_bits(64),
           rand_bits(64), 1'b0, 1'b0, ex_pkg::BSRC_RS2, ex_pkg::BR_NONE, 6);
    run_op("backpressure remw", ex_pkg::ALU_REM, rand_bits(64), rand_bits(64), rand_bits(64),
           rand_bits(64), 1'b0, 1'b1, ex_pkg::BSRC_RS2, ex_pkg::BR_NE, 4);
    run_op("after backpressure", ex_pkg::ALU_XOR, rand_bits(64), rand_bits(64),
           rand_bits(64), rand_bits(64), 1'b0, 1'b0, ex_pkg::BSRC_IMM, ex_pkg::BR_NONE, 0);
  endtask

  initial begin
    i_rst       = 1'b1;
    i_valid     = 1'b0;
    i_rs1       = '0;
    i_rs2       = '0;
    i_imm       = '0;
    i_pc        = '0;
    i_alu_op    = ex_pkg::ALU_ADD;
    i_a_pc      = 1'b0;
    i_word_cut  = 1'b0;
    i_b_src     = ex_pkg::BSRC_RS2;
    i_branch    = ex_pkg::BR_NONE;
    i_res_ready = 1'b0;
    lfsr        = 32'hd597;
    n_checks    = 0;
    n_errors    = 0;
    repeat (3) @(posedge i_clk);
    i_rst <= 1'b0;
    @(negedge i_clk);
    n_checks++;
    if (o_ready !== 1'b1 || o_res_valid !== 1'b0) begin
      n_errors++;
      $display("error reset: expected ready 1 valid 0 actual ready %b valid %b",
               o_ready, o_res_valid);
    end
    basic_alu_ops();
    word_forms_and_compares();
    multiplies();
    divides();
    branch_targets();
    result_backpressure();
    $display("checks %0d errors %0d", n_checks, n_errors);
    if (n_errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/ex_top.sv
// ex_top: RV64IM execute stage with valid/ready issue and result handshakes
`timescale 1ns/1ns
`default_nettype none

module ex_top (
  input  logic            i_clk,
  input  logic            i_rst,
  input  logic            i_valid,
  output logic            o_ready,
  input  ex_pkg::xlen_t   i_rs1,
  input  ex_pkg::xlen_t   i_rs2,
  input  ex_pkg::xlen_t   i_imm,
  input  ex_pkg::xlen_t   i_pc,
  input  ex_pkg::alu_op_t i_alu_op,
  input  logic            i_a_pc,
  input  logic            i_word_cut,
  input  ex_pkg::bsrc_t   i_b_src,
  input  ex_pkg::branch_t i_branch,
  output logic            o_res_valid,
  input  logic            i_res_ready,
  output ex_pkg::xlen_t   o_result,
  output ex_pkg::xlen_t   o_next_pc
);

  ex_pkg::xlen_t alu_result, next_pc;
  logic          alu_zero, alu_less;
  logic          div_start, div_signed, div_rem, div_done;
  ex_pkg::xlen_t div_a, div_b, div_result;

  ex_op_if u_op_if ();

  ex_ctrl u_ctrl (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_valid      (i_valid),
    .o_ready      (o_ready),
    .i_rs1        (i_rs1),
    .i_rs2        (i_rs2),
    .i_imm        (i_imm),
    .i_pc         (i_pc),
    .i_alu_op     (i_alu_op),
    .i_a_pc       (i_a_pc),
    .i_word_cut   (i_word_cut),
    .i_b_src      (i_b_src),
    .i_branch     (i_branch),
    .op           (u_op_if.ctrl),
    .i_alu_result (alu_result),
    .i_next_pc    (next_pc),
    .o_div_start  (div_start),
    .o_div_signed (div_signed),
    .o_div_rem    (div_rem),
    .o_div_a      (div_a),
    .o_div_b      (div_b),
    .i_div_done   (div_done),
    .i_div_result (div_result),
    .o_res_valid  (o_res_valid),
    .i_res_ready  (i_res_ready),
    .o_result     (o_result),
    .o_next_pc    (o_next_pc)
  );

  ex_alu u_alu (
    .op       (u_op_if.exec),
    .o_result (alu_result),
    .o_zero   (alu_zero),
    .o_less   (alu_less)
  );

  ex_divider u_divider (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_start  (div_start),
    .i_signed (div_signed),
    .i_rem    (div_rem),
    .i_word   (u_op_if.word_cut),
    .i_a      (div_a),
    .i_b      (div_b),
    .o_done   (div_done),
    .o_result (div_result)
  );

  ex_branch u_branch (
    .op        (u_op_if.exec),
    .i_zero    (alu_zero),
    .i_less    (alu_less),
    .o_next_pc (next_pc)
  );

endmodule

`default_nettype wire

//--- hw/ex_ctrl.sv
// ex_ctrl: holds the issued instruction, sequences the divider and runs both handshakes
`timescale 1ns/1ns
`default_nettype none

module ex_ctrl (
  input  logic            i_clk,
  input  logic            i_rst,
  input  logic            i_valid,
  output logic            o_ready,
  input  ex_pkg::xlen_t   i_rs1,
  input  ex_pkg::xlen_t   i_rs2,
  input  ex_pkg::xlen_t   i_imm,
  input  ex_pkg::xlen_t   i_pc,
  input  ex_pkg::alu_op_t i_alu_op,
  input  logic            i_a_pc,
  input  logic            i_word_cut,
  input  ex_pkg::bsrc_t   i_b_src,
  input  ex_pkg::branch_t i_branch,
  ex_op_if.ctrl           op,
  input  ex_pkg::xlen_t   i_alu_result,
  input  ex_pkg::xlen_t   i_next_pc,
  output logic            o_div_start,
  output logic            o_div_signed,
  output logic            o_div_rem,
  output ex_pkg::xlen_t   o_div_a,
  output ex_pkg::xlen_t   o_div_b,
  input  logic            i_div_done,
  input  ex_pkg::xlen_t   i_div_result,
  output logic            o_res_valid,
  input  logic            i_res_ready,
  output ex_pkg::xlen_t   o_result,
  output ex_pkg::xlen_t   o_next_pc
);

  ex_pkg::ctrl_state_t state;
  logic                pending;
  logic                is_div;
  ex_pkg::xlen_t       src_a, src_b;

  // pending marks the cycle after issue when the held fields are evaluated
  assign o_ready     = (state == ex_pkg::IDLE) && !pending;
  assign o_res_valid = (state == ex_pkg::HOLD);

  assign is_div = (op.alu_op == ex_pkg::ALU_DIV) || (op.alu_op == ex_pkg::ALU_DIVU) ||
                  (op.alu_op == ex_pkg::ALU_REM) || (op.alu_op == ex_pkg::ALU_REMU);
  assign o_div_signed = (op.alu_op == ex_pkg::ALU_DIV) || (op.alu_op == ex_pkg::ALU_REM);
  assign o_div_rem    = (op.alu_op == ex_pkg::ALU_REM) || (op.alu_op == ex_pkg::ALU_REMU);
  assign o_div_start  = pending && is_div;

  assign src_a = op.a_pc ? op.pc : op.rs1;
  always_comb begin
    case (op.b_src)
      ex_pkg::BSRC_IMM:  src_b = op.imm;
      ex_pkg::BSRC_FOUR: src_b = 64'd4;
      default:           src_b = op.rs2;
    endcase
  end

  // word division works on sign-extended low words
  assign o_div_a = op.word_cut ? {{32{src_a[31]}}, src_a[31:0]} : src_a;
  assign o_div_b = op.word_cut ? {{32{src_b[31]}}, src_b[31:0]} : src_b;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state   <= ex_pkg::IDLE;
      pending <= 1'b0;
    end else begin
      case (state)
        ex_pkg::IDLE: begin
          if (pending) begin
            pending <= 1'b0;
            state   <= is_div ? ex_pkg::DIVIDE : ex_pkg::HOLD;
          end else if (i_valid) begin
            pending <= 1'b1;
          end
        end
        ex_pkg::DIVIDE: if (i_div_done) state <= ex_pkg::HOLD;
        ex_pkg::HOLD:   if (i_res_ready) state <= ex_pkg::IDLE;
        default:        state <= ex_pkg::IDLE;
      endcase
    end
  end

  // held instruction fields
  always_ff @(posedge i_clk) begin
    if (i_valid && o_ready) begin
      op.rs1      <= i_rs1;
      op.rs2      <= i_rs2;
      op.imm      <= i_imm;
      op.pc       <= i_pc;
      op.alu_op   <= i_alu_op;
      op.a_pc     <= i_a_pc;
      op.word_cut <= i_word_cut;
      op.b_src    <= i_b_src;
      op.branch   <= i_branch;
    end
  end

  // result and next pc registers
  always_ff @(posedge i_clk) begin
    if (pending) begin
      o_next_pc <= i_next_pc;
      if (!is_div)
        o_result <= i_alu_result;
    end else if (state == ex_pkg::DIVIDE && i_div_done) begin
      o_result <= op.word_cut ? {{32{i_div_result[31]}}, i_div_result[31:0]} : i_div_result;
    end
  end

  // the divider may only finish while the control waits for it
  a_done_in_divide: assert property (@(posedge i_clk) disable iff (i_rst)
    i_div_done |-> (state == ex_pkg::DIVIDE));

  a_result_held: assert property (@(posedge i_clk) disable iff (i_rst)
    o_res_valid && !i_res_ready |=> o_res_valid && $stable(o_result) && $stable(o_next_pc));

endmodule

`default_nettype wire

//--- hw/ex_branch.sv
// ex_branch: branch decision and next-pc adder
`timescale 1ns/1ns
`default_nettype none

module ex_branch (
  ex_op_if.exec         op,
  input  logic          i_zero,
  input  logic          i_less,
  output ex_pkg::xlen_t o_next_pc
);

  logic          taken;
  ex_pkg::xlen_t base, offset;

  always_comb begin
    case (op.branch)
      ex_pkg::BR_NONE: taken = 1'b0;
      ex_pkg::BR_JAL,
      ex_pkg::BR_JALR: taken = 1'b1;
      ex_pkg::BR_EQ:   taken = i_zero;
      ex_pkg::BR_NE:   taken = ~i_zero;
      ex_pkg::BR_LT:   taken = i_less;
      ex_pkg::BR_GE:   taken = ~i_less;
      default:         taken = 1'b0;
    endcase
  end

  // jalr is the only rs1-relative target
  assign base      = (op.branch == ex_pkg::BR_JALR) ? op.rs1 : op.pc;
  assign offset    = taken ? op.imm : 64'd4;
  assign o_next_pc = base + offset;

endmodule

`default_nettype wire

//--- hw/ex_divider.sv
// ex_divider: iterative restoring divider for signed and unsigned quotient and remainder
`timescale 1ns/1ns
`default_nettype none

module ex_divider (
  input  logic          i_clk,
  input  logic          i_rst,
  input  logic          i_start,
  input  logic          i_signed,
  input  logic          i_rem,
  input  logic          i_word,
  input  ex_pkg::xlen_t i_a,
  input  ex_pkg::xlen_t i_b,
  output logic          o_done,
  output ex_pkg::xlen_t o_result
);

  logic          a_neg, b_neg;
  ex_pkg::xlen_t a_abs, b_abs, a_mag, b_mag;
  logic          busy;
  logic [6:0]    count;
  ex_pkg::xlen_t quo, rem, divisor;
  logic          neg_q, neg_r, b_zero, rem_sel;
  logic [64:0]   trial, diff;
  ex_pkg::xlen_t quo_fix, rem_fix;

  // magnitudes with word operands taken from the low 32 bits
  assign a_neg = i_signed & (i_word ? i_a[31] : i_a[63]);
  assign b_neg = i_signed & (i_word ? i_b[31] : i_b[63]);
  assign a_abs = a_neg ? -i_a : i_a;
  assign b_abs = b_neg ? -i_b : i_b;
  assign a_mag = i_word ? {32'b0, a_abs[31:0]} : a_abs;
  assign b_mag = i_word ? {32'b0, b_abs[31:0]} : b_abs;

  // shift in the next dividend bit and keep the difference if it did not underflow
  assign trial = {rem, quo[63]};
  assign diff  = trial - {1'b0, divisor};

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy   <= 1'b0;
      count  <= '0;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (i_start) begin
        busy  <= 1'b1;
        count <= i_word ? 7'd32 : 7'd64;
      end else if (busy) begin
        count <= count - 7'd1;
        if (count == 7'd1) begin
          busy   <= 1'b0;
          o_done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      // word dividend sits in the top half so 32 steps consume it
      quo     <= i_word ? {a_mag[31:0], 32'b0} : a_mag;
      rem     <= '0;
      divisor <= b_mag;
      neg_q   <= a_neg ^ b_neg;
      neg_r   <= a_neg;
      b_zero  <= (b_mag == '0);
      rem_sel <= i_rem;
    end else if (busy) begin
      if (!diff[64]) begin
        rem <= diff[63:0];
        quo <= {quo[62:0], 1'b1};
      end else begin
        rem <= trial[63:0];
        quo <= {quo[62:0], 1'b0};
      end
    end
  end

  // on overflow |min| / 1 with no sign change gives min back
  assign quo_fix  = b_zero ? '1 : (neg_q ? -quo : quo);
  assign rem_fix  = neg_r ? -rem : rem;
  assign o_result = rem_sel ? rem_fix : quo_fix;

  a_no_restart: assert property (@(posedge i_clk) disable iff (i_rst) i_start |-> !busy);

endmodule

`default_nettype wire

//--- hw/ex_alu.sv
// ex_alu: combinational ALU for all non-division operations with zero and less flags
`timescale 1ns/1ns
`default_nettype none

module ex_alu (
  ex_op_if.exec         op,
  output ex_pkg::xlen_t o_result,
  output logic          o_zero,
  output logic          o_less
);

  ex_pkg::xlen_t src1, src2, imm;
  ex_pkg::xlen_t src_a, src_b;
  ex_pkg::xlen_t diff, sra_full, raw;
  logic          carry, ovf, lt_s, lt_u;
  logic [5:0]    shamt;
  logic [31:0]   sra_word;
  logic          mul_a_signed, mul_b_signed;
  logic [127:0]  mul_a, mul_b, product;

  // word forms work on zero-extended low words
  assign src1 = op.word_cut ? {32'b0, op.rs1[31:0]} : op.rs1;
  assign src2 = op.word_cut ? {32'b0, op.rs2[31:0]} : op.rs2;
  assign imm  = op.word_cut ? {32'b0, op.imm[31:0]} : op.imm;

  assign src_a = op.a_pc ? op.pc : src1;

  always_comb begin
    case (op.b_src)
      ex_pkg::BSRC_IMM:  src_b = imm;
      ex_pkg::BSRC_FOUR: src_b = 64'd4;
      default:           src_b = src2;
    endcase
  end

  // a - b as a + ~b + 1 where carry out means no borrow
  assign {carry, diff} = {1'b0, src_a} + {1'b0, ~src_b} + 65'd1;
  assign ovf  = (src_a[63] ^ src_b[63]) & (diff[63] ^ src_a[63]);
  assign lt_s = diff[63] ^ ovf;
  assign lt_u = ~carry;

  assign o_zero = (diff == '0);
  assign o_less = (op.alu_op == ex_pkg::ALU_SLTU) ? lt_u : lt_s;

  assign shamt    = op.word_cut ? {1'b0, src_b[4:0]} : src_b[5:0];
  assign sra_full = $signed(src_a) >>> shamt;
  assign sra_word = $signed(src_a[31:0]) >>> shamt[4:0];

  // one 128-bit multiplier whose operand extension picks the mulh flavour
  assign mul_a_signed = (op.alu_op == ex_pkg::ALU_MULH) || (op.alu_op == ex_pkg::ALU_MULHSU);
  assign mul_b_signed = (op.alu_op == ex_pkg::ALU_MULH);
  assign mul_a   = {{64{mul_a_signed & src_a[63]}}, src_a};
  assign mul_b   = {{64{mul_b_signed & src_b[63]}}, src_b};
  assign product = mul_a * mul_b;

  always_comb begin
    case (op.alu_op)
      ex_pkg::ALU_ADD:    raw = src_a + src_b;
      ex_pkg::ALU_SUB:    raw = diff;
      ex_pkg::ALU_SLT:    raw = {63'b0, lt_s};
      ex_pkg::ALU_SLTU:   raw = {63'b0, lt_u};
      ex_pkg::ALU_XOR:    raw = src_a ^ src_b;
      ex_pkg::ALU_AND:    raw = src_a & src_b;
      ex_pkg::ALU_OR:     raw = src_a | src_b;
      ex_pkg::ALU_SLL:    raw = src_a << shamt;
      ex_pkg::ALU_SRL:    raw = src_a >> shamt;
      ex_pkg::ALU_SRA:    raw = op.word_cut ? {{32{sra_word[31]}}, sra_word} : sra_full;
      ex_pkg::ALU_MUL:    raw = product[63:0];
      ex_pkg::ALU_MULH,
      ex_pkg::ALU_MULHSU,
      ex_pkg::ALU_MULHU:  raw = product[127:64];
      ex_pkg::ALU_COPY:   raw = op.imm;
      // div and rem come from the divider
      default:            raw = '0;
    endcase
  end

  // word results are sign-extended from bit 31
  assign o_result = op.word_cut ? {{32{raw[31]}}, raw[31:0]} : raw;

endmodule

`default_nettype wire

//--- hw/ex_op_if.sv
// ex_op_if: held instruction fields passed from the control module to the datapath
`timescale 1ns/1ns
`default_nettype none

interface ex_op_if;

  ex_pkg::xlen_t   rs1;
  ex_pkg::xlen_t   rs2;
  ex_pkg::xlen_t   imm;
  ex_pkg::xlen_t   pc;
  ex_pkg::alu_op_t alu_op;
  logic            a_pc;
  logic            word_cut;
  ex_pkg::bsrc_t   b_src;
  ex_pkg::branch_t branch;

  // control side writes the fields
  modport ctrl (output rs1, rs2, imm, pc, alu_op, a_pc, word_cut, b_src, branch);

  // datapath side only reads them
  modport exec (input rs1, rs2, imm, pc, alu_op, a_pc, word_cut, b_src, branch);

endinterface

`default_nettype wire

//--- hw/ex_pkg.sv
// ex_pkg: shared widths, operation and branch codes, and control states of the execute stage
`default_nettype none

package ex_pkg;

  localparam int XLEN = 64;

  // operands, pc and results
  typedef logic [XLEN-1:0] xlen_t;

  // alu operation codes
  typedef logic [4:0] alu_op_t;
  localparam alu_op_t ALU_ADD    = 5'd0;
  localparam alu_op_t ALU_SUB    = 5'd1;
  localparam alu_op_t ALU_SLT    = 5'd2;
  localparam alu_op_t ALU_SLTU   = 5'd3;
  localparam alu_op_t ALU_XOR    = 5'd4;
  localparam alu_op_t ALU_AND    = 5'd5;
  localparam alu_op_t ALU_OR     = 5'd6;
  localparam alu_op_t ALU_SLL    = 5'd7;
  localparam alu_op_t ALU_SRL    = 5'd8;
  localparam alu_op_t ALU_SRA    = 5'd9;
  localparam alu_op_t ALU_MUL    = 5'd10;
  localparam alu_op_t ALU_DIV    = 5'd11;
  localparam alu_op_t ALU_DIVU   = 5'd12;
  localparam alu_op_t ALU_REM    = 5'd13;
  localparam alu_op_t ALU_REMU   = 5'd14;
  localparam alu_op_t ALU_COPY   = 5'd15;
  localparam alu_op_t ALU_MULH   = 5'd25;
  localparam alu_op_t ALU_MULHSU = 5'd26;
  localparam alu_op_t ALU_MULHU  = 5'd27;

  // branch codes where lt and ge rely on the less flag
  typedef logic [2:0] branch_t;
  localparam branch_t BR_NONE = 3'd0;
  localparam branch_t BR_JAL  = 3'd1;
  localparam branch_t BR_JALR = 3'd2;
  localparam branch_t BR_EQ   = 3'd4;
  localparam branch_t BR_NE   = 3'd5;
  localparam branch_t BR_LT   = 3'd6;
  localparam branch_t BR_GE   = 3'd7;

  // second operand source
  typedef logic [1:0] bsrc_t;
  localparam bsrc_t BSRC_RS2  = 2'd0;
  localparam bsrc_t BSRC_IMM  = 2'd1;
  localparam bsrc_t BSRC_FOUR = 2'd2;

  typedef enum logic [1:0] {IDLE, DIVIDE, HOLD} ctrl_state_t;

endpackage

`default_nettype wire
